// ==== osd_readout.f ====
source/osd_pkg.sv
source/video_if.sv
source/timing_gen_xy.sv
source/readout_digits.sv
source/seg_glyph.sv
source/text_overlay.sv
source/osd_top.sv
verification/tb_osd_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the OSD readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_osd_top \
	-f osd_readout.f -Mdir obj_dir -o sim_osd
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_osd)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^test passed$"; then
	exit 0
fi
exit 1

// ==== source/osd_pkg.sv ====
package osd_pkg;

	// active screen, kept small
	localparam int H_ACT = 64;
	localparam int V_ACT = 48;

	localparam int COORD_W = 7;   // holds 0..H_ACT
	localparam int PIX_W = 24;
	localparam int VAL_W = 11;    // min, max, voltage
	localparam int FRE_W = 32;
	localparam int DEC_W = 10;    // enough for 0..999

	// text placement
	localparam int TEXT_X = 8;
	localparam int ROW_Y0 = 2;
	localparam int ROW_PITCH = 12;

	// one digit cell
	localparam int CELL_W = 8;
	localparam int CELL_H = 8;
	localparam int CELL_AW = $clog2(CELL_W);

	// rows: min, max, frequency, voltage
	localparam int N_ROWS = 4;
	localparam int N_DIGITS = 3;
	localparam int ROW_IDX_W = $clog2(N_ROWS);
	localparam int DIG_IDX_W = $clog2(N_DIGITS);
	localparam int TEXT_W = N_DIGITS * CELL_W;

	// frequency above this is shown in thousands
	localparam logic [FRE_W-1:0] FRE_DIV = 32'd1000;

	localparam logic [DEC_W-1:0] DIGIT_MAX = 10'd999;

	typedef logic [3:0] digit_t;

endpackage

// ==== source/osd_top.sv ====
`timescale 1ns/100ps

module osd_top (
	input  logic                      pclk,
	input  logic                      rst_n,
	input  logic                      i_hs,
	input  logic                      i_vs,
	input  logic                      i_de,
	input  logic [osd_pkg::PIX_W-1:0] i_data,
	input  logic [osd_pkg::PIX_W-1:0] i_text_color,
	input  logic [osd_pkg::VAL_W-1:0] i_min,
	input  logic [osd_pkg::VAL_W-1:0] i_max,
	input  logic [osd_pkg::FRE_W-1:0] i_fre,
	input  logic [osd_pkg::VAL_W-1:0] i_volt,
	output logic                      o_hs,
	output logic                      o_vs,
	output logic                      o_de,
	output logic [osd_pkg::PIX_W-1:0] o_data
);

	osd_pkg::digit_t digits [osd_pkg::N_ROWS][osd_pkg::N_DIGITS];

	video_if u_vid ();

	// stage 1, registered stream with coordinates
	timing_gen_xy u_timing (
		.i_clk   (pclk),
		.i_rst_n (rst_n),
		.i_hs    (i_hs),
		.i_vs    (i_vs),
		.i_de    (i_de),
		.i_data  (i_data),
		.o_vid   (u_vid.src)
	);

	// values latched once per frame
	readout_digits u_digits (
		.pclk     (pclk),
		.rst_n    (rst_n),
		.i_vs     (i_vs),
		.i_min    (i_min),
		.i_max    (i_max),
		.i_volt   (i_volt),
		.i_fre    (i_fre),
		.o_digits (digits)
	);

	// stage 2
	text_overlay u_overlay (
		.pclk         (pclk),
		.rst_n        (rst_n),
		.i_vid        (u_vid.snk),
		.i_digits     (digits),
		.i_text_color (i_text_color),
		.o_hs         (o_hs),
		.o_vs         (o_vs),
		.o_de         (o_de),
		.o_data       (o_data)
	);

endmodule

// ==== source/readout_digits.sv ====
`timescale 1ns/100ps

module readout_digits (
	input  logic                      pclk,
	input  logic                      rst_n,
	input  logic                      i_vs,
	input  logic [osd_pkg::VAL_W-1:0] i_min,
	input  logic [osd_pkg::VAL_W-1:0] i_max,
	input  logic [osd_pkg::VAL_W-1:0] i_volt,
	input  logic [osd_pkg::FRE_W-1:0] i_fre,
	output osd_pkg::digit_t           o_digits [osd_pkg::N_ROWS][osd_pkg::N_DIGITS]
);

	logic vs_q;
	logic frame_start;
	logic [osd_pkg::FRE_W-1:0] fre_scaled;
	logic [osd_pkg::DEC_W-1:0] val [osd_pkg::N_ROWS];
	osd_pkg::digit_t nxt_digits [osd_pkg::N_ROWS][osd_pkg::N_DIGITS];

	// saturate to three decimal digits
	function automatic logic [osd_pkg::DEC_W-1:0] clamp_val(
		input logic [osd_pkg::FRE_W-1:0] v
	);
		if (v > osd_pkg::DIGIT_MAX) begin
			return osd_pkg::DIGIT_MAX;
		end
		return v[osd_pkg::DEC_W-1:0];
	endfunction

	assign fre_scaled = (i_fre >= osd_pkg::FRE_DIV) ? i_fre / osd_pkg::FRE_DIV : i_fre;

	assign val[0] = clamp_val({{(osd_pkg::FRE_W - osd_pkg::VAL_W){1'b0}}, i_min});
	assign val[1] = clamp_val({{(osd_pkg::FRE_W - osd_pkg::VAL_W){1'b0}}, i_max});
	assign val[2] = clamp_val(fre_scaled);
	assign val[3] = clamp_val({{(osd_pkg::FRE_W - osd_pkg::VAL_W){1'b0}}, i_volt});

	// units into the last slot, hundreds end up in slot 0
	always_comb begin
		logic [osd_pkg::DEC_W-1:0] rem;
		logic [osd_pkg::DEC_W-1:0] q;
		for (int r = 0; r < osd_pkg::N_ROWS; r++) begin
			rem = val[r];
			for (int d = osd_pkg::N_DIGITS - 1; d >= 0; d--) begin
				q = rem % 4'd10;
				nxt_digits[r][d] = q[3:0];
				rem = rem / 4'd10;
			end
		end
	end

	assign frame_start = i_vs & ~vs_q;

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			vs_q <= 1'b0;
		end else begin
			vs_q <= i_vs;
		end
	end

	// held for the whole frame
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			for (int r = 0; r < osd_pkg::N_ROWS; r++) begin
				for (int d = 0; d < osd_pkg::N_DIGITS; d++) begin
					o_digits[r][d] <= '0;
				end
			end
		end else if (frame_start) begin
			o_digits <= nxt_digits;
		end
	end

endmodule

// ==== source/seg_glyph.sv ====
`timescale 1ns/100ps

module seg_glyph (
	input  osd_pkg::digit_t             i_digit,
	input  logic [osd_pkg::CELL_AW-1:0] i_col,
	input  logic [osd_pkg::CELL_AW-1:0] i_row,
	output logic                        o_on
);

	logic [6:0] seg;   // a b c d e f g, msb first
	logic horiz;
	logic left;
	logic right;
	logic upper;
	logic lower;

	always_comb begin
		case (i_digit)
			4'd0:    seg = 7'b1111110;
			4'd1:    seg = 7'b0110000;
			4'd2:    seg = 7'b1101101;
			4'd3:    seg = 7'b1111001;
			4'd4:    seg = 7'b0110011;
			4'd5:    seg = 7'b1011011;
			4'd6:    seg = 7'b1011111;
			4'd7:    seg = 7'b1110000;
			4'd8:    seg = 7'b1111111;
			4'd9:    seg = 7'b1111011;
			default: seg = 7'b0000000;   // not a decimal digit
		endcase
	end

	// bar spans and stroke columns inside the cell
	assign horiz = (i_col >= 3'd1) && (i_col <= 3'd4);
	assign left  = (i_col == 3'd0);
	assign right = (i_col == 3'd5);
	assign upper = (i_row == 3'd1) || (i_row == 3'd2);
	assign lower = (i_row == 3'd4) || (i_row == 3'd5);

	assign o_on = (seg[6] && horiz && i_row == 3'd0) ||   // a
	              (seg[5] && right && upper) ||           // b
	              (seg[4] && right && lower) ||           // c
	              (seg[3] && horiz && i_row == 3'd6) ||   // d
	              (seg[2] && left && lower) ||            // e
	              (seg[1] && left && upper) ||            // f
	              (seg[0] && horiz && i_row == 3'd3);     // g

endmodule

// ==== source/text_overlay.sv ====
`timescale 1ns/100ps

module text_overlay (
	input  logic                      pclk,
	input  logic                      rst_n,
	video_if.snk                      i_vid,
	input  osd_pkg::digit_t           i_digits [osd_pkg::N_ROWS][osd_pkg::N_DIGITS],
	input  logic [osd_pkg::PIX_W-1:0] i_text_color,
	output logic                      o_hs,
	output logic                      o_vs,
	output logic                      o_de,
	output logic [osd_pkg::PIX_W-1:0] o_data
);

	logic row_hit;
	logic col_hit;
	logic win;
	logic [osd_pkg::ROW_IDX_W-1:0] row_sel;
	logic [osd_pkg::DIG_IDX_W-1:0] dig_sel;
	logic [osd_pkg::CELL_AW-1:0] cell_col;
	logic [osd_pkg::CELL_AW-1:0] cell_row;
	osd_pkg::digit_t cur_digit;
	logic glyph_on;

	// locate the pixel inside the text column
	always_comb begin
		int x_off;
		int x_dig;
		int y_off;
		row_hit = 1'b0;
		row_sel = '0;
		cell_row = '0;
		x_off = int'(i_vid.x) - osd_pkg::TEXT_X;
		x_dig = x_off / osd_pkg::CELL_W;
		col_hit = (x_off >= 0) && (x_off < osd_pkg::TEXT_W);
		dig_sel = x_dig[osd_pkg::DIG_IDX_W-1:0];
		cell_col = x_off[osd_pkg::CELL_AW-1:0];
		for (int k = 0; k < osd_pkg::N_ROWS; k++) begin
			y_off = int'(i_vid.y) - (osd_pkg::ROW_Y0 + k * osd_pkg::ROW_PITCH);
			if ((y_off >= 0) && (y_off < osd_pkg::CELL_H)) begin
				row_hit = 1'b1;
				row_sel = k[osd_pkg::ROW_IDX_W-1:0];
				cell_row = y_off[osd_pkg::CELL_AW-1:0];
			end
		end
	end

	assign win = row_hit & col_hit;

	// outside the windows the index may point past the last digit
	assign cur_digit = win ? i_digits[row_sel][dig_sel] : '0;

	seg_glyph u_glyph (
		.i_digit (cur_digit),
		.i_col   (cell_col),
		.i_row   (cell_row),
		.o_on    (glyph_on)
	);

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			o_hs   <= 1'b0;
			o_vs   <= 1'b0;
			o_de   <= 1'b0;
			o_data <= '0;
		end else begin
			o_hs <= i_vid.hs;
			o_vs <= i_vid.vs;
			o_de <= i_vid.de;
			if (i_vid.de && win && glyph_on) begin
				o_data <= i_text_color;
			end else begin
				o_data <= i_vid.data;   // pass through
			end
		end
	end

endmodule

// ==== source/timing_gen_xy.sv ====
`timescale 1ns/100ps

module timing_gen_xy (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_hs,
	input  logic                      i_vs,
	input  logic                      i_de,
	input  logic [osd_pkg::PIX_W-1:0] i_data,
	video_if.src                      o_vid
);

	logic de_fall;

	// o_vid.de is the previous input de
	assign de_fall = o_vid.de & ~i_de;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_vid.hs <= 1'b0;
			o_vid.vs <= 1'b0;
			o_vid.de <= 1'b0;
		end else begin
			o_vid.hs <= i_hs;
			o_vid.vs <= i_vs;
			o_vid.de <= i_de;
		end
	end

	// pixel x, lines up with the registered pixel
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_vid.x <= '0;
		end else if (i_de) begin
			if (o_vid.de) begin
				o_vid.x <= o_vid.x + 1'b1;
			end else begin
				o_vid.x <= '0;   // first pixel of the line
			end
		end else begin
			o_vid.x <= '0;
		end
	end

	// line count, one step per end of active line
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_vid.y <= '0;
		end else if (i_vs) begin
			o_vid.y <= '0;
		end else if (de_fall) begin
			o_vid.y <= o_vid.y + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		o_vid.data <= i_data;
	end

endmodule

// ==== source/video_if.sv ====
`timescale 1ns/100ps

// one pixel of the stream plus where it sits on screen
interface video_if;

	logic hs;
	logic vs;
	logic de;
	logic [osd_pkg::PIX_W-1:0] data;
	logic [osd_pkg::COORD_W-1:0] x;   // pixel within active line
	logic [osd_pkg::COORD_W-1:0] y;   // active line number

	modport src (
		output hs,
		output vs,
		output de,
		output data,
		output x,
		output y
	);

	modport snk (
		input hs,
		input vs,
		input de,
		input data,
		input x,
		input y
	);

endinterface

// ==== verification/tb_osd_top.sv ====
`timescale 1ns/100ps

module tb_osd_top;

	localparam int LINE_CYC = 80;      // 64 active plus 16 blanking
	localparam int FRAME_LINES = 52;   // 48 active plus 4 with vs high
	localparam int FRAME_CYC = FRAME_LINES * LINE_CYC;
	localparam int N_FRAMES = 10;      // frames driven over all tests
	localparam int MAX_CYCLES = (N_FRAMES + 1) * FRAME_CYC + 100;
	localparam int EXP_W = osd_pkg::PIX_W + 3;
	localparam logic [osd_pkg::PIX_W-1:0] TEXT_COLOR = 24'h40ff20;

	logic pclk;
	logic rst_n;
	logic i_hs;
	logic i_vs;
	logic i_de;
	logic [osd_pkg::PIX_W-1:0] i_data;
	logic [osd_pkg::PIX_W-1:0] i_text_color;
	logic [osd_pkg::VAL_W-1:0] i_min;
	logic [osd_pkg::VAL_W-1:0] i_max;
	logic [osd_pkg::FRE_W-1:0] i_fre;
	logic [osd_pkg::VAL_W-1:0] i_volt;
	logic o_hs;
	logic o_vs;
	logic o_de;
	logic [osd_pkg::PIX_W-1:0] o_data;

	integer seed = 52;
	int errors = 0;
	int checks = 0;
	int errors_at_start = 0;
	int cycle_cnt = 0;
	bit check_en = 1'b0;

	int shown [osd_pkg::N_ROWS];       // numbers on screen this frame
	int pending [osd_pkg::N_ROWS];     // numbers for the values now driven
	int staged_num [osd_pkg::N_ROWS];
	logic [osd_pkg::VAL_W-1:0] staged_min;
	logic [osd_pkg::VAL_W-1:0] staged_max;
	logic [osd_pkg::FRE_W-1:0] staged_fre;
	logic [osd_pkg::VAL_W-1:0] staged_volt;

	// {hs, vs, de, data} expected at the output
	logic [EXP_W-1:0] exp_now = '0;
	logic [EXP_W-1:0] exp_d1 = '0;
	logic [EXP_W-1:0] exp_d2 = '0;

	osd_top i_dut (
		.pclk         (pclk),
		.rst_n        (rst_n),
		.i_hs         (i_hs),
		.i_vs         (i_vs),
		.i_de         (i_de),
		.i_data       (i_data),
		.i_text_color (i_text_color),
		.i_min        (i_min),
		.i_max        (i_max),
		.i_fre        (i_fre),
		.i_volt       (i_volt),
		.o_hs         (o_hs),
		.o_vs         (o_vs),
		.o_de         (o_de),
		.o_data       (o_data)
	);

	initial begin
		pclk = 1'b0;
		forever #20 pclk = ~pclk;
	end

	always @(posedge pclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	// two stage delay, matches the DUT latency
	always @(posedge pclk) begin
		exp_d1 <= exp_now;
		exp_d2 <= exp_d1;
	end

	always @(negedge pclk) begin
		if (check_en) begin
			check("o_hs", o_hs, exp_d2[EXP_W-1]);
			check("o_vs", o_vs, exp_d2[EXP_W-2]);
			check("o_de", o_de, exp_d2[EXP_W-3]);
			check("o_data", o_data, exp_d2[osd_pkg::PIX_W-1:0]);
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
		checks++;
		if (got !== expv) begin
			errors++;
			$display("FAILED %s: got %h expected %h", name, got, expv);
		end
	endtask

	// segment letters lit for each decimal digit
	function automatic string digit_segments(input int dg);
		case (dg)
			0: return "abcdef";
			1: return "bc";
			2: return "abdeg";
			3: return "abcdg";
			4: return "bcfg";
			5: return "acdfg";
			6: return "acdefg";
			7: return "abc";
			8: return "abcdefg";
			default: return "abcdfg";
		endcase
	endfunction

	function automatic bit segment_lit(input int dg, input int col, input int row);
		string segs;
		bit on;
		bit bar;
		segs = digit_segments(dg);
		on = 1'b0;
		bar = (col >= 1) && (col <= 4);
		for (int i = 0; i < segs.len(); i++) begin
			case (segs[i])
				"a": on |= bar && (row == 0);
				"g": on |= bar && (row == 3);
				"d": on |= bar && (row == 6);
				"f": on |= (col == 0) && (row == 1 || row == 2);
				"b": on |= (col == 5) && (row == 1 || row == 2);
				"e": on |= (col == 0) && (row == 4 || row == 5);
				"c": on |= (col == 5) && (row == 4 || row == 5);
				default: on |= 1'b0;
			endcase
		end
		return on;
	endfunction

	function automatic logic [osd_pkg::PIX_W-1:0] expected_pixel(
		input logic de,
		input int x,
		input int y,
		input logic [osd_pkg::PIX_W-1:0] d
	);
		int top;
		int slot;
		int dg;
		logic [osd_pkg::PIX_W-1:0] r;
		r = d;
		if (de && x >= osd_pkg::TEXT_X && x < osd_pkg::TEXT_X + 3 * osd_pkg::CELL_W) begin
			slot = (x - osd_pkg::TEXT_X) / osd_pkg::CELL_W;
			for (int k = 0; k < osd_pkg::N_ROWS; k++) begin
				top = osd_pkg::ROW_Y0 + k * osd_pkg::ROW_PITCH;
				if (y >= top && y < top + osd_pkg::CELL_H) begin
					if (slot == 0) dg = shown[k] / 100;   // hundreds first
					else if (slot == 1) dg = (shown[k] / 10) % 10;
					else dg = shown[k] % 10;
					if (segment_lit(dg, (x - osd_pkg::TEXT_X) % osd_pkg::CELL_W, y - top)) begin
						r = TEXT_COLOR;
					end
				end
			end
		end
		return r;
	endfunction

	task automatic drive_pixel(input logic hs, input logic vs, input logic de,
		input int x, input int y);
		logic [osd_pkg::PIX_W-1:0] d;
		@(posedge pclk);
		d = $random(seed);
		i_hs <= hs;
		i_vs <= vs;
		i_de <= de;
		i_data <= d;
		exp_now <= {hs, vs, de, expected_pixel(de, x, y, d)};
	endtask

	task automatic drive_line(input logic vs, input int y);
		for (int c = 0; c < LINE_CYC; c++) begin
			drive_pixel(c >= 68 && c < 72, vs, !vs && c < osd_pkg::H_ACT, c, y);
		end
	endtask

	// change_line < 0 keeps the values for the whole frame
	task automatic drive_frame(input int change_line);
		for (int l = 0; l < osd_pkg::V_ACT; l++) begin
			drive_line(1'b0, l);
			if (l == change_line) apply_values();
		end
		for (int k = 0; k < osd_pkg::N_ROWS; k++) begin
			shown[k] = pending[k];   // captured as vs rises
		end
		for (int l = 0; l < FRAME_LINES - osd_pkg::V_ACT; l++) begin
			drive_line(1'b1, 0);
		end
	endtask

	task automatic set_values(input int vmin, input int vmax, input int vfre, input int vvolt,
		input int smin, input int smax, input int sfre, input int svolt);
		staged_min = vmin;
		staged_max = vmax;
		staged_fre = vfre;
		staged_volt = vvolt;
		staged_num[0] = smin;
		staged_num[1] = smax;
		staged_num[2] = sfre;
		staged_num[3] = svolt;
	endtask

	// called right after a rising edge
	task automatic apply_values();
		i_min <= staged_min;
		i_max <= staged_max;
		i_fre <= staged_fre;
		i_volt <= staged_volt;
		for (int k = 0; k < osd_pkg::N_ROWS; k++) begin
			pending[k] = staged_num[k];
		end
	endtask

	task automatic check_idle();
		check("o_hs", o_hs, 0);
		check("o_vs", o_vs, 0);
		check("o_de", o_de, 0);
		check("o_data", o_data, 0);
	endtask

	task automatic report_test(input string name);
		$display("%-12s done, %0d mismatches", name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	// busy stream while in reset, quiet for the last cycles before release
	task automatic test_reset();
		logic [osd_pkg::PIX_W-1:0] d;
		logic act;
		for (int i = 0; i < 7; i++) begin
			@(posedge pclk);
			act = (i < 5);
			d = $random(seed);
			i_hs <= act;
			i_vs <= act;
			i_de <= act;
			i_data <= act ? d : '0;
			@(negedge pclk);
			check_idle();
		end
		@(posedge pclk);
		rst_n <= 1'b1;
		repeat (3) begin
			@(negedge pclk);
			check_idle();
		end
		check_en = 1'b1;
		report_test("reset");
	endtask

	task automatic test_passthrough();
		drive_frame(-1);   // text still shows 000
		report_test("passthrough");
	endtask

	task automatic test_digits();
		set_values(123, 456, 90, 789, 123, 456, 90, 789);
		apply_values();
		drive_frame(-1);
		drive_frame(-1);
		report_test("digits");
	endtask

	task automatic test_scaling();
		set_values(123, 456, 45000, 789, 123, 456, 45, 789);
		apply_values();
		drive_frame(-1);
		set_values(123, 456, 999, 789, 123, 456, 999, 789);
		apply_values();
		drive_frame(-1);
		drive_frame(-1);
		report_test("scaling");
	endtask

	task automatic test_clamp();
		set_values(7, 2000, 5000000, 305, 7, 999, 999, 305);
		apply_values();
		drive_frame(-1);
		drive_frame(-1);
		report_test("clamp");
	endtask

	task automatic test_capture();
		set_values(321, 654, 1234, 987, 321, 654, 1, 987);
		drive_frame(23);   // new values halfway down
		drive_frame(-1);
		report_test("capture");
	endtask

	initial begin
		rst_n <= 1'b0;
		i_hs <= 1'b0;
		i_vs <= 1'b0;
		i_de <= 1'b0;
		i_data <= '0;
		i_text_color <= TEXT_COLOR;
		i_min <= '0;
		i_max <= '0;
		i_fre <= '0;
		i_volt <= '0;

		test_reset();
		test_passthrough();
		test_digits();
		test_scaling();
		test_clamp();
		test_capture();

		repeat (4) @(negedge pclk);   // drain the pipeline
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
